//--- design/xy_scope_pkg.sv
package xy_scope_pkg;

  // adc and framebuffer geometry
  localparam int adc_bits = 10;
  localparam int fb_width = 64;
  localparam int fb_height = 48;
  localparam int fb_x_bits = 6;
  localparam int fb_y_bits = 6;
  localparam int fb_addr_bits = 12;
  localparam int fb_pixels = fb_width * fb_height;

  // one bit each for r, g, b
  localparam int color_bits = 3;
  localparam logic [color_bits-1:0] bg_color = 3'b001;
  localparam logic [color_bits-1:0] trace_color = 3'b111;

  localparam int settle_cycles = 8;
  localparam int start_cycles = 8;

  // video mode, horizontal in clocks
  localparam int h_visible = 64;
  localparam int h_front = 4;
  localparam int h_sync = 6;
  localparam int h_back = 6;
  localparam int h_total = h_visible + h_front + h_sync + h_back;
  localparam int h_cnt_bits = $clog2(h_total);

  // vertical in lines
  localparam int v_visible = 48;
  localparam int v_front = 2;
  localparam int v_sync = 2;
  localparam int v_back = 2;
  localparam int v_total = v_visible + v_front + v_sync + v_back;
  localparam int v_cnt_bits = $clog2(v_total);

  typedef struct packed {
    logic [adc_bits-1:0] x;
    logic [adc_bits-1:0] y;
  } adc_sample_t;

  typedef struct packed {
    logic [fb_x_bits-1:0] x;
    logic [fb_y_bits-1:0] y;
  } fb_point_t;

  typedef struct packed {
    logic [fb_x_bits-1:0]  x;
    logic [fb_y_bits-1:0]  y;
    logic [color_bits-1:0] color;
  } pixel_wr_t;

  // syncs are active low
  typedef struct packed {
    logic                  hsync;
    logic                  vsync;
    logic                  de;
    logic [color_bits-1:0] color;
  } vga_out_t;

  typedef enum logic [1:0] {
    src_clear,
    src_settle,
    src_plot
  } src_state_t;

endpackage

//--- design/adc_xy_capture.sv
`timescale 1ns/10ps

module adc_xy_capture
  import xy_scope_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                strobe,
  input  logic [adc_bits-1:0] adc_x_bus,
  input  logic [adc_bits-1:0] adc_y_bus,
  input  logic                ready,
  output logic                valid,
  output adc_sample_t         sample,
  output logic                overrun
);

  logic load;

  // single entry, only loads when empty
  assign load = strobe && !valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid   <= 1'b0;
      overrun <= 1'b0;
    end else begin
      if (load) begin
        valid <= 1'b1;
      end else if (ready) begin
        valid <= 1'b0;
      end
      // sticky, strobe found the entry occupied
      if (strobe && valid) begin
        overrun <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      sample.x <= adc_x_bus;
      sample.y <= adc_y_bus;
    end
  end

endmodule

//--- design/xy_scaler.sv
`timescale 1ns/10ps

module xy_scaler
  import xy_scope_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        in_valid,
  input  adc_sample_t in_sample,
  input  logic        out_ready,
  output logic        in_ready,
  output logic        out_valid,
  output fb_point_t   out_point
);

  logic [adc_bits+1:0] y_times3;
  logic                load;

  // y * 3 / 64 keeps 0..1023 inside 0..47
  assign y_times3 = (adc_bits + 2)'(in_sample.y) * (adc_bits + 2)'(3);

  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      // x / 16 is just the top bits
      out_point.x <= in_sample.x[adc_bits-1 -: fb_x_bits];
      out_point.y <= y_times3[adc_bits+1 -: fb_y_bits];
    end
  end

endmodule

//--- design/pixel_source.sv
`timescale 1ns/10ps

module pixel_source
  import xy_scope_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      in_valid,
  input  fb_point_t in_point,
  input  logic      wr_ready,
  input  logic      wr_ack_last,
  output logic      in_ready,
  output logic      wr_valid,
  output pixel_wr_t wr,
  output logic      clear_done
);

  src_state_t              state;
  logic [fb_addr_bits-1:0] clr_cnt;
  logic                    clr_issued;
  logic [fb_addr_bits-1:0] ack_cnt;
  logic [3:0]              settle_cnt;
  logic                    take;

  // output register free or being drained
  assign take = !wr_valid || wr_ready;

  // points are swallowed until plotting starts
  assign in_ready = (state == src_plot) ? take : 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= src_clear;
      wr_valid   <= 1'b0;
      clr_cnt    <= '0;
      clr_issued <= 1'b0;
      ack_cnt    <= '0;
      settle_cnt <= '0;
      clear_done <= 1'b0;
    end else begin
      case (state)
        src_clear: begin
          if (take) begin
            wr_valid <= !clr_issued;
            if (!clr_issued) begin
              clr_cnt    <= clr_cnt + 1'b1;
              clr_issued <= (clr_cnt == fb_addr_bits'(fb_pixels - 1));
            end
          end
          // wait for the last write to land, not just be issued
          if (wr_ack_last) begin
            ack_cnt <= ack_cnt + 1'b1;
            if (ack_cnt == fb_addr_bits'(fb_pixels - 1)) begin
              state <= src_settle;
            end
          end
        end
        src_settle: begin
          settle_cnt <= settle_cnt + 1'b1;
          if (settle_cnt == 4'(settle_cycles - 1)) begin
            state      <= src_plot;
            clear_done <= 1'b1;
          end
        end
        src_plot: begin
          if (take) begin
            wr_valid <= in_valid;
          end
        end
        default: state <= src_clear;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      if (state == src_plot) begin
        wr <= {in_point.x, in_point.y, trace_color};
      end else begin
        // raster order, address is y * 64 + x
        wr <= {clr_cnt[fb_x_bits-1:0], clr_cnt[fb_addr_bits-1 -: fb_y_bits], bg_color};
      end
    end
  end

endmodule

//--- design/fb_wb_master.sv
`timescale 1ns/10ps

module fb_wb_master
  import xy_scope_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wr_valid,
  input  pixel_wr_t               wr,
  input  logic                    wb_ack,
  output logic                    wr_ready,
  output logic                    wr_ack_last,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output logic [fb_addr_bits-1:0] wb_adr,
  output logic [color_bits-1:0]   wb_dat
);

  logic start;

  // one write in flight at a time
  assign wr_ready    = !wb_cyc;
  assign start       = wr_valid && wr_ready;
  assign wr_ack_last = wb_cyc && wb_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end else if (start) begin
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= 1'b1;
    end else if (wr_ack_last) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end
  end

  // address and data held for the whole cycle
  always_ff @(posedge clk) begin
    if (start) begin
      wb_adr <= {wr.y, wr.x};
      wb_dat <= wr.color;
    end
  end

endmodule

//--- design/framebuffer_ram.sv
`timescale 1ns/10ps

module framebuffer_ram
  import xy_scope_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [fb_addr_bits-1:0] wb_adr,
  input  logic [color_bits-1:0]   wb_dat,
  input  logic [fb_addr_bits-1:0] rd_addr,
  output logic                    wb_ack,
  output logic [color_bits-1:0]   rd_data
);

  logic [color_bits-1:0] mem [fb_pixels];
  logic                  req;

  // new request only when no ack is outstanding
  assign req = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req && wb_we) begin
      mem[wb_adr] <= wb_dat;
    end
  end

  // scanout side, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- design/vga_scanout.sv
`timescale 1ns/10ps

module vga_scanout
  import xy_scope_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [color_bits-1:0]   rd_data,
  output logic [fb_addr_bits-1:0] rd_addr,
  output vga_out_t                vga
);

  logic [3:0]            start_cnt;
  logic                  running;
  logic [h_cnt_bits-1:0] h_cnt;
  logic [v_cnt_bits-1:0] v_cnt;
  logic                  de_c;
  logic                  hsync_c;
  logic                  vsync_c;
  logic                  de_d;
  logic                  hsync_d;
  logic                  vsync_d;

  // hold off the first frame after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      start_cnt <= '0;
      running   <= 1'b0;
    end else if (!running) begin
      start_cnt <= start_cnt + 1'b1;
      if (start_cnt == 4'(start_cycles - 1)) begin
        running <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (running) begin
      if (h_cnt == h_cnt_bits'(h_total - 1)) begin
        h_cnt <= '0;
        if (v_cnt == v_cnt_bits'(v_total - 1)) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // position decode, idle levels until running
  assign de_c = running && (h_cnt < h_cnt_bits'(h_visible)) &&
                (v_cnt < v_cnt_bits'(v_visible));
  assign hsync_c = !(running && (h_cnt >= h_cnt_bits'(h_visible + h_front)) &&
                     (h_cnt < h_cnt_bits'(h_visible + h_front + h_sync)));
  assign vsync_c = !(running && (v_cnt >= v_cnt_bits'(v_visible + v_front)) &&
                     (v_cnt < v_cnt_bits'(v_visible + v_front + v_sync)));

  // only read inside the visible area
  assign rd_addr = de_c ? {v_cnt[fb_y_bits-1:0], h_cnt[fb_x_bits-1:0]} : '0;

  // delay controls to meet the ram read data
  always_ff @(posedge clk) begin
    if (reset) begin
      de_d    <= 1'b0;
      hsync_d <= 1'b1;
      vsync_d <= 1'b1;
    end else begin
      de_d    <= de_c;
      hsync_d <= hsync_c;
      vsync_d <= vsync_c;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vga <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, color: '0};
    end else begin
      vga.hsync <= hsync_d;
      vga.vsync <= vsync_d;
      vga.de    <= de_d;
      vga.color <= de_d ? rd_data : '0;
    end
  end

endmodule

//--- design/adc_xy_vga.sv
`timescale 1ns/10ps

module adc_xy_vga
  import xy_scope_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                adc_strobe,
  input  logic [adc_bits-1:0] adc_x_bus,
  input  logic [adc_bits-1:0] adc_y_bus,
  output vga_out_t            vga,
  output logic                clear_done,
  output logic                overrun
);

  // capture to scaler
  logic        cap_valid;
  logic        cap_ready;
  adc_sample_t cap_sample;

  // scaler to source
  logic      pt_valid;
  logic      pt_ready;
  fb_point_t pt;

  // source to wishbone master
  logic      wr_valid;
  logic      wr_ready;
  logic      wr_ack_last;
  pixel_wr_t wr;

  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic                    wb_ack;
  logic [fb_addr_bits-1:0] wb_adr;
  logic [color_bits-1:0]   wb_dat;

  logic [fb_addr_bits-1:0] rd_addr;
  logic [color_bits-1:0]   rd_data;

  adc_xy_capture capture_i (
    .clk       (clk),
    .reset     (reset),
    .strobe    (adc_strobe),
    .adc_x_bus (adc_x_bus),
    .adc_y_bus (adc_y_bus),
    .ready     (cap_ready),
    .valid     (cap_valid),
    .sample    (cap_sample),
    .overrun   (overrun)
  );

  xy_scaler scaler_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (cap_valid),
    .in_sample (cap_sample),
    .out_ready (pt_ready),
    .in_ready  (cap_ready),
    .out_valid (pt_valid),
    .out_point (pt)
  );

  pixel_source source_i (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (pt_valid),
    .in_point    (pt),
    .wr_ready    (wr_ready),
    .wr_ack_last (wr_ack_last),
    .in_ready    (pt_ready),
    .wr_valid    (wr_valid),
    .wr          (wr),
    .clear_done  (clear_done)
  );

  fb_wb_master master_i (
    .clk         (clk),
    .reset       (reset),
    .wr_valid    (wr_valid),
    .wr          (wr),
    .wb_ack      (wb_ack),
    .wr_ready    (wr_ready),
    .wr_ack_last (wr_ack_last),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat      (wb_dat)
  );

  framebuffer_ram fb_i (
    .clk     (clk),
    .reset   (reset),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat  (wb_dat),
    .rd_addr (rd_addr),
    .wb_ack  (wb_ack),
    .rd_data (rd_data)
  );

  vga_scanout scanout_i (
    .clk     (clk),
    .reset   (reset),
    .rd_data (rd_data),
    .rd_addr (rd_addr),
    .vga     (vga)
  );

endmodule

//--- verif/adc_xy_vga_tb.sv
`timescale 1ns/10ps

module adc_xy_vga_tb
  import xy_scope_pkg::*;
();

  localparam int n_rows = 16;
  localparam int n_cols = 5;
  localparam int n_pixels = 64 * 48;
  localparam logic [2:0] exp_bg = 3'b001;
  localparam logic [2:0] exp_trace = 3'b111;
  localparam int line_cycles = 80;
  localparam int frame_cycles = line_cycles * 54;
  // clear writes, frames waited or captured, strobe gaps, margin
  localparam int cycle_limit = n_pixels * 3 + 4 * frame_cycles + n_rows * 12 + 2000;

  logic                clk;
  logic                reset;
  logic                adc_strobe;
  logic [adc_bits-1:0] adc_x_bus;
  logic [adc_bits-1:0] adc_y_bus;
  vga_out_t            vga;
  logic                clear_done;
  logic                overrun;

  // one row per sample with x code, y code, x, y and during-clear flag
  logic [15:0] td [n_rows * n_cols];
  logic [2:0]  frame [n_pixels];
  logic [2:0]  exp_image [n_pixels];

  int   cycle_cnt = 0;
  int   pix_idx = 0;
  int   vfall_cnt = 0;
  logic prev_hsync;
  logic prev_vsync;
  logic hfall_seen;
  int   mon_cycle;
  int   last_hfall;
  int   hlow_len;
  int   vlow_len;
  int   de_line_cnt;
  int   de_lines;

  adc_xy_vga dut_i (
    .clk        (clk),
    .reset      (reset),
    .adc_strobe (adc_strobe),
    .adc_x_bus  (adc_x_bus),
    .adc_y_bus  (adc_y_bus),
    .vga        (vga),
    .clear_done (clear_done),
    .overrun    (overrun)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected_val);
    if (actual !== expected_val) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected_val);
      $display("Test failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("run did not finish within %0d clock cycles", cycle_limit);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  // sample registered outputs half a cycle after the edge
  always @(negedge clk) begin
    if (reset) begin
      prev_hsync  = 1'b1;
      prev_vsync  = 1'b1;
      hfall_seen  = 1'b0;
      mon_cycle   = 0;
      last_hfall  = 0;
      hlow_len    = 0;
      vlow_len    = 0;
      de_line_cnt = 0;
      de_lines    = 0;
    end else begin
      mon_cycle = mon_cycle + 1;
      if (vga.de) begin
        de_line_cnt = de_line_cnt + 1;
        // raster order gives index y * 64 + x
        if (pix_idx < n_pixels) begin
          frame[pix_idx] = vga.color;
          pix_idx = pix_idx + 1;
        end
      end
      if (!vga.hsync) hlow_len = hlow_len + 1;
      if (!vga.vsync) vlow_len = vlow_len + 1;
      if (prev_hsync && !vga.hsync) begin
        if (hfall_seen) check_value("hsync period", mon_cycle - last_hfall, line_cycles);
        hfall_seen = 1'b1;
        last_hfall = mon_cycle;
        if (de_line_cnt != 0) begin
          check_value("de cycles per line", de_line_cnt, 64);
          de_lines = de_lines + 1;
        end
        de_line_cnt = 0;
      end
      if (!prev_hsync && vga.hsync) begin
        check_value("hsync low cycles", hlow_len, 6);
        hlow_len = 0;
      end
      if (prev_vsync && !vga.vsync) begin
        check_value("de lines per frame", de_lines, 48);
        de_lines = 0;
        pix_idx = 0;
        vfall_cnt = vfall_cnt + 1;
      end
      if (!prev_vsync && vga.vsync) begin
        check_value("vsync low cycles", vlow_len, 2 * line_cycles);
        vlow_len = 0;
      end
      prev_hsync = vga.hsync;
      prev_vsync = vga.vsync;
    end
  end

  task automatic check_testdata();
    int r;
    if ($isunknown(td[n_rows * n_cols - 1])) begin
      $display("testdata file could not be read or has too few rows");
      $display("Test failed");
      $fatal(1, "no stimulus");
    end
    // x is code / 16 and y is code * 3 / 64 rounded down
    for (r = 0; r < n_rows; r++) begin
      check_value("testdata x", 32'(td[r*n_cols+2]), td[r*n_cols] / 16);
      check_value("testdata y", 32'(td[r*n_cols+3]), (td[r*n_cols+1] * 3) / 64);
      check_value("testdata y in range", 32'(td[r*n_cols+3] < 48), 1);
    end
  endtask

  // idle levels until the first frame starts
  task automatic check_idle_outputs();
    repeat (8) begin
      @(negedge clk);
      check_value("vga.de", 32'(vga.de), 0);
      check_value("vga.hsync", 32'(vga.hsync), 1);
      check_value("vga.vsync", 32'(vga.vsync), 1);
      check_value("vga.color", 32'(vga.color), 0);
      check_value("clear_done", 32'(clear_done), 0);
      check_value("overrun", 32'(overrun), 0);
    end
  endtask

  task automatic send_sample(input logic [15:0] x_code, input logic [15:0] y_code);
    int gap;
    gap = 4 + int'($urandom % 9);
    @(posedge clk);
    #10;
    adc_strobe = 1'b1;
    adc_x_bus  = x_code[adc_bits-1:0];
    adc_y_bus  = y_code[adc_bits-1:0];
    @(posedge clk);
    #10;
    adc_strobe = 1'b0;
    repeat (gap - 2) @(posedge clk);
    #10;
  endtask

  task automatic wait_vsync_fall();
    int target;
    target = vfall_cnt + 1;
    wait (vfall_cnt >= target);
  endtask

  task automatic grab_frame();
    wait_vsync_fall();
    wait (pix_idx == n_pixels);
  endtask

  task automatic compare_frame();
    int i;
    for (i = 0; i < n_pixels; i++) begin
      check_value($sformatf("pixel x=%0d y=%0d color", i % 64, i / 64),
                  32'(frame[i]), 32'(exp_image[i]));
    end
  endtask

  initial begin
    int r;
    reset      = 1'b1;
    adc_strobe = 1'b0;
    adc_x_bus  = '0;
    adc_y_bus  = '0;
    void'($urandom(68020));
    $readmemh("verif/adc_xy_vga_testdata.txt", td);
    check_testdata();
    repeat (2) @(posedge clk);
    #10;
    reset = 1'b0;
    check_idle_outputs();

    // strobe near the end of the clear so a stray write would not be cleared over
    repeat (n_pixels * 3 - 200) @(posedge clk);
    #10;

    // these must be swallowed while clearing
    for (r = 0; r < n_rows; r++) begin
      if (td[r*n_cols+4] == 16'h1) begin
        check_value("clear_done", 32'(clear_done), 0);
        send_sample(td[r*n_cols], td[r*n_cols+1]);
      end
    end
    wait (clear_done === 1'b1);
    for (r = 0; r < n_pixels; r++) exp_image[r] = exp_bg;
    grab_frame();
    compare_frame();

    for (r = 0; r < n_rows; r++) begin
      if (td[r*n_cols+4] == 16'h0) begin
        send_sample(td[r*n_cols], td[r*n_cols+1]);
        exp_image[td[r*n_cols+3] * 64 + td[r*n_cols+2]] = exp_trace;
      end
    end
    // finish the frame in progress and then capture a whole new one
    wait_vsync_fall();
    grab_frame();
    compare_frame();

    check_value("overrun", 32'(overrun), 0);
    check_value("clear_done", 32'(clear_done), 1);
    $display("Test passed");
    $finish;
  end

endmodule

//--- verif/adc_xy_vga_testdata.txt
// columns: x_code y_code exp_x exp_y during_clear (all hex)
// exp_x = x_code / 16, exp_y = y_code * 3 / 64, rows flagged 1 go in during clear
321 123 32 0d 1
0a0 300 0a 24 1
3a0 080 3a 06 1
150 250 15 1b 1
000 000 00 00 0
3ff 3ff 3f 2f 0
000 3ff 00 2f 0
3ff 000 3f 00 0
200 200 20 18 0
100 155 10 0f 0
010 015 01 00 0
2ab 2ab 2a 20 0
0f3 3c0 0f 2d 0
37f 0aa 37 07 0
1e0 2c5 1e 21 0
07f 15b 07 10 0

//--- files.f
design/xy_scope_pkg.sv
design/adc_xy_capture.sv
design/xy_scaler.sv
design/pixel_source.sv
design/fb_wb_master.sv
design/framebuffer_ram.sv
design/vga_scanout.sv
design/adc_xy_vga.sv
verif/adc_xy_vga_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= adc_xy_vga_tb
FILELIST  ?= files.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
